//--- bench/rwgen_assert.sv
// AXI request protocol checks for the traffic generator top level
// Payload held while stalled, AR and AW never together, done only in a run.

`timescale 1ns/1ps

module rwgen_assert #(
    parameter int ADDR_W = rwgen_pkg::ADDR_W,
    parameter int ID_W   = rwgen_pkg::ID_W
) (
    input logic                 axi4_mm_clk,
    input logic                 rst_n,
    input logic                 arvalid,
    input logic                 arready,
    input logic [ADDR_W-1:0]    araddr,
    input logic [ID_W-1:0]      arid,
    input rwgen_pkg::axi_user_t aruser,
    input logic                 awvalid,
    input logic                 awready,
    input logic [ADDR_W-1:0]    awaddr,
    input logic [ID_W-1:0]      awid,
    input rwgen_pkg::axi_user_t awuser,
    input logic                 busy,
    input logic                 done
);

    import rwgen_pkg::*;

    ar_hold: assert property (@(posedge axi4_mm_clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid) && $stable(aruser))
        else $error("AR request dropped or changed while stalled");

    aw_hold: assert property (@(posedge axi4_mm_clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid) && $stable(awuser))
        else $error("AW request dropped or changed while stalled");

    one_channel: assert property (@(posedge axi4_mm_clk) disable iff (!rst_n)
        !(arvalid && awvalid))
        else $error("arvalid and awvalid high together");

    done_in_run: assert property (@(posedge axi4_mm_clk) disable iff (!rst_n)
        done |-> busy)
        else $error("done high while busy is low");

endmodule

bind rwgen_top rwgen_assert #(.ADDR_W(ADDR_W), .ID_W(ID_W)) i_assert (
    .axi4_mm_clk(axi4_mm_clk), .rst_n(rst_n),
    .arvalid(arvalid), .arready(arready), .araddr(araddr), .arid(arid), .aruser(aruser),
    .awvalid(awvalid), .awready(awready), .awaddr(awaddr), .awid(awid), .awuser(awuser),
    .busy(busy), .done(done)
);

//--- bench/rwgen_tb.sv
// Traffic generator testbench
// Directed runs against a reference address model, with a ready model
// that is either always high or driven from an LCG.

`timescale 1ns/1ps

module rwgen_tb;

    import rwgen_pkg::*;

    localparam int TOTAL_REQ = 8 + 6 + 10 + 12 + 5 * 6 + 2 * 4;
    localparam int TIMEOUT   = TOTAL_REQ * 20 + 500;

    typedef struct packed {
        addr_t     addr;
        id_t       id;
        axi_user_t user;
    } beat_t;

    logic axi4_mm_clk = 1'b0;
    logic rst_n = 1'b0;
    logic start = 1'b0;
    logic arready = 1'b0;
    logic awready = 1'b0;
    logic wready = 1'b0;
    run_cfg_t cfg = '0;
    logic arvalid, awvalid, wvalid, wlast, busy, done;
    addr_t araddr, awaddr;
    id_t arid, awid;
    axi_user_t aruser, awuser;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W/8-1:0] wstrb;
    logic [CNT_W-1:0] issued_cnt, stall_cnt;

    logic [31:0] lcg_state = 32'h9cbdc80e;
    bit rand_ready = 1'b0;
    beat_t ar_q[$], aw_q[$], exp_q[$];
    int ncyc = 0, start_at = 0, first_valid_at = 0;
    int w_cnt = 0, w_bad = 0, stall_seen = 0, cycles = 0;
    int errors = 0, test_err = 0, tests_run = 0, tests_failed = 0;
    logic busy_after_start, busy_after_done;
    logic [CNT_W-1:0] issued_after_start, stall_after_start;
    string cur_test;

    rwgen_top i_dut (
        .axi4_mm_clk, .rst_n, .cfg, .start,
        .arvalid, .araddr, .arid, .aruser, .arready,
        .awvalid, .awaddr, .awid, .awuser, .awready,
        .wvalid, .wdata, .wstrb, .wlast, .wready,
        .busy, .done, .issued_cnt, .stall_cnt
    );

    initial forever #2 axi4_mm_clk = ~axi4_mm_clk;   // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // slave ready model
    always @(posedge axi4_mm_clk) begin
        if (rand_ready) begin
            lcg_state = lcg_next(lcg_state);
            arready <= lcg_state[31];
            awready <= lcg_state[29];
            wready  <= lcg_state[27];
        end else begin
            arready <= 1'b1;
            awready <= 1'b1;
            wready  <= 1'b1;
        end
    end

    // bus monitor sampling mid-cycle
    always @(negedge axi4_mm_clk) begin
        ncyc = ncyc + 1;
        if (start) begin   // new run clears the record
            start_at = ncyc;
            first_valid_at = 0;
            ar_q.delete();
            aw_q.delete();
            w_cnt = 0;
            w_bad = 0;
            stall_seen = 0;
        end
        if ((arvalid || awvalid) && first_valid_at == 0) first_valid_at = ncyc;
        if (arvalid && arready) ar_q.push_back({araddr, arid, aruser});
        if (awvalid && awready) aw_q.push_back({awaddr, awid, awuser});
        if (wvalid && wready) begin
            w_cnt = w_cnt + 1;
            if (wdata !== '1 || wstrb !== '1 || wlast !== 1'b1) w_bad = w_bad + 1;
        end
        if ((arvalid && !arready) || (awvalid && !awready) || (wvalid && !wready)) begin
            stall_seen = stall_seen + 1;   // once per cycle
        end
    end

    initial begin
        while (cycles < TIMEOUT) begin
            @(posedge axi4_mm_clk);
            cycles = cycles + 1;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Finished with errors");
        $finish;
    end

    function automatic int keep_bits(input range_sel_e sel);
        case (sel)
            RNG_32K:  return 9;
            RNG_128K: return 11;
            RNG_1M:   return 14;
            RNG_4M:   return 16;
            RNG_16M:  return 18;
            RNG_32M:  return 19;
            default:  return 0;
        endcase
    endfunction

    function automatic logic [63:0] range_limit(input range_sel_e sel);
        case (sel)
            RNG_32K:  return 64'h8000;
            RNG_128K: return 64'h2_0000;
            RNG_1M:   return 64'h10_0000;
            RNG_4M:   return 64'h40_0000;
            RNG_16M:  return 64'h100_0000;
            default:  return 64'h200_0000;
        endcase
    endfunction

    function automatic run_cfg_t make_cfg(input bit wr, input region_e rgn,
            input access_class_e cls, input range_sel_e sel, input int num,
            input logic [63:0] base, input logic [63:0] seed);
        run_cfg_t c;
        c.is_write    = wr;
        c.region      = rgn;
        c.acc_class   = cls;
        c.range_sel   = sel;
        c.num_request = CNT_W'(num);
        c.page_base   = base;
        c.seed        = seed;
        return c;
    endfunction

    // reference model of the request rule
    task automatic compute_expected(input run_cfg_t c);
        logic [63:0] s;
        logic [63:0] off;
        beat_t b;
        int n;
        exp_q.delete();
        s = c.seed;
        n = int'(c.num_request);
        for (int k = 0; k < n; k++) begin
            if (c.range_sel == RNG_SEQ) off = 64'(k) * 64'd64;
            else off = (s & ((64'd1 << keep_bits(c.range_sel)) - 64'd1)) << 6;
            b.addr = c.page_base + off;
            b.id = id_t'(k);
            b.user.region = c.region;
            b.user.rsvd = 2'b00;
            b.user.acc_class = c.acc_class;
            exp_q.push_back(b);
            s = s ^ (s << 1) ^ (s >> 1);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic end_test();
        tests_run = tests_run + 1;
        if (test_err == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d checks failed", cur_test, test_err);
        end
    endtask

    task automatic report_value(input string what, input logic [63:0] exp,
            input logic [63:0] act);
        $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        test_err = test_err + 1;
        errors = errors + 1;
    endtask

    task automatic report_fault(input string msg);
        $display("test %s: %s", cur_test, msg);
        test_err = test_err + 1;
        errors = errors + 1;
    endtask

    task automatic set_ready_mode(input bit random_mode);
        @(negedge axi4_mm_clk);
        rand_ready = random_mode;
    endtask

    // one start pulse, then wait for done
    task automatic run_burst(input run_cfg_t c);
        compute_expected(c);
        @(posedge axi4_mm_clk);
        cfg <= c;
        start <= 1'b1;
        @(posedge axi4_mm_clk);
        start <= 1'b0;
        @(negedge axi4_mm_clk);
        busy_after_start = busy;
        issued_after_start = issued_cnt;
        stall_after_start = stall_cnt;
        while (done !== 1'b1) @(negedge axi4_mm_clk);
        @(negedge axi4_mm_clk);
        busy_after_done = busy;
    endtask

    task automatic compare_stream(input bit use_aw);
        beat_t got[$];
        if (use_aw) begin
            got = aw_q;
        end else begin
            got = ar_q;
        end
        if (got.size() != exp_q.size()) report_value("request count", exp_q.size(), got.size());
        for (int i = 0; i < exp_q.size() && i < got.size(); i++) begin
            if (got[i].addr !== exp_q[i].addr)
                report_value($sformatf("addr[%0d]", i), exp_q[i].addr, got[i].addr);
            if (got[i].id !== exp_q[i].id)
                report_value($sformatf("id[%0d]", i), 64'(exp_q[i].id), 64'(got[i].id));
            if (got[i].user !== exp_q[i].user)
                report_value($sformatf("user[%0d]", i), 64'(exp_q[i].user), 64'(got[i].user));
        end
    endtask

    task automatic random_read_burst();
        begin_test("random_read");
        set_ready_mode(1'b0);
        run_burst(make_cfg(1'b0, RGN_HOST, ACC_SHARED_OWN, RNG_32K, 8,
                           64'h0000_0040_0000_0000, 64'hace1_0f5e_9d37_21b4));
        compare_stream(1'b0);
        if (first_valid_at - start_at != 3)
            report_value("start to arvalid", 64'd3, 64'(first_valid_at - start_at));
        if (issued_cnt !== 16'd8) report_value("issued_cnt", 64'd8, 64'(issued_cnt));
        if (stall_cnt !== 16'd0) report_value("stall_cnt", 64'd0, 64'(stall_cnt));
        end_test();
    endtask

    task automatic seq_write_burst();
        begin_test("seq_write");
        run_burst(make_cfg(1'b1, RGN_HDM_DEV_BIAS, ACC_OWN_PUSH, RNG_SEQ, 6,
                           64'h0000_0001_2345_6000, 64'h0123_4567_89ab_cdef));
        compare_stream(1'b1);
        foreach (aw_q[i]) begin
            if (aw_q[i].user !== 6'b110010) report_value("awuser", 64'b110010, 64'(aw_q[i].user));
        end
        if (w_cnt != 6) report_value("write beats", 64'd6, 64'(w_cnt));
        if (w_bad != 0) report_fault("write beat without full data, strobes or wlast");
        if (issued_cnt !== 16'd6) report_value("issued_cnt", 64'd6, 64'(issued_cnt));
        end_test();
    endtask

    task automatic indep_aw_w_write();
        begin_test("independent_aw_w");
        set_ready_mode(1'b1);
        run_burst(make_cfg(1'b1, RGN_HOST, ACC_NC, RNG_1M, 10,
                           64'h0000_0002_0000_0000, 64'h5a5a_3c3c_0f0f_9669));
        set_ready_mode(1'b0);
        compare_stream(1'b1);
        if (w_cnt != 10) report_value("write beats", 64'd10, 64'(w_cnt));
        if (issued_cnt !== 16'd10) report_value("issued_cnt", 64'd10, 64'(issued_cnt));
        end_test();
    endtask

    task automatic stall_counting();
        begin_test("stall_count");
        set_ready_mode(1'b1);
        run_burst(make_cfg(1'b0, RGN_HDM_HOST_BIAS, ACC_SHARED_OWN, RNG_4M, 12,
                           64'h0000_0003_0000_0000, 64'hdead_beef_1357_2468));
        set_ready_mode(1'b0);
        compare_stream(1'b0);
        if (stall_cnt !== CNT_W'(stall_seen))
            report_value("stall_cnt", 64'(stall_seen), 64'(stall_cnt));
        if (issued_cnt !== 16'd12) report_value("issued_cnt", 64'd12, 64'(issued_cnt));
        end_test();
    endtask

    task automatic all_range_reads();
        logic [63:0] base;
        logic [63:0] off;
        range_sel_e sel;
        begin_test("all_ranges");
        base = 64'h0000_0010_0000_0000;
        for (int r = 2; r <= 6; r++) begin
            sel = range_sel_e'(r);
            run_burst(make_cfg(1'b0, RGN_HDM_HOST_BIAS, ACC_NC, sel, 6, base,
                               64'h9e37_79b9_7f4a_7c15 ^ 64'(r)));
            compare_stream(1'b0);
            foreach (ar_q[i]) begin
                off = ar_q[i].addr - base;
                if (off >= range_limit(sel))
                    report_fault($sformatf("range %0d offset %h out of range", r, off));
                if (ar_q[i].addr[5:0] !== 6'd0)
                    report_value("line offset bits", 64'd0, 64'(ar_q[i].addr[5:0]));
            end
        end
        end_test();
    endtask

    task automatic back_to_back_runs();
        begin_test("back_to_back");
        for (int run = 0; run < 2; run++) begin
            run_burst(make_cfg(run[0], RGN_HOST, ACC_NC, RNG_SEQ, 4,
                               64'h0000_0000_8000_0000, 64'h1));
            if (busy_after_start !== 1'b1) report_fault("busy did not rise after start");
            if (busy_after_done !== 1'b0) report_fault("busy did not fall after done");
            if (issued_after_start !== 16'd0)
                report_value("issued_cnt after start", 64'd0, 64'(issued_after_start));
            if (stall_after_start !== 16'd0)
                report_value("stall_cnt after start", 64'd0, 64'(stall_after_start));
            compare_stream(run[0]);   // ids restart at 0
            if (issued_cnt !== 16'd4) report_value("issued_cnt", 64'd4, 64'(issued_cnt));
        end
        end_test();
    endtask

    initial begin
        repeat (16) @(posedge axi4_mm_clk);
        rst_n <= 1'b1;
        @(negedge axi4_mm_clk);
        begin_test("reset_state");
        if (arvalid !== 1'b0 || awvalid !== 1'b0 || wvalid !== 1'b0
                || busy !== 1'b0 || done !== 1'b0)
            report_fault("valid, busy or done not low after reset");
        if (issued_cnt !== 16'd0) report_value("issued_cnt", 64'd0, 64'(issued_cnt));
        if (stall_cnt !== 16'd0) report_value("stall_cnt", 64'd0, 64'(stall_cnt));
        end_test();
        random_read_burst();
        seq_write_burst();
        indep_aw_w_write();
        stall_counting();
        all_range_reads();
        back_to_back_runs();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/rwgen_pkg.sv
verilog/req_fifo.sv
verilog/req_producer.sv
verilog/axi_issue.sv
verilog/rwgen_top.sv
bench/rwgen_assert.sv
bench/rwgen_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the traffic generator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG="Finished with no errors"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rwgen_tb -f build.f \
    --Mdir obj_dir -o rwgen_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rwgen_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- verilog/axi_issue.sv
// AXI4 request issuer
// Takes requests from the FIFO head and presents them on AR, or on AW and
// W, which are accepted independently. Counts completed requests and
// stalled cycles, and pulses done when the last request of a run finishes.

`timescale 1ns/1ps

module axi_issue #(
    parameter int ADDR_W = rwgen_pkg::ADDR_W,
    parameter int ID_W   = rwgen_pkg::ID_W
) (
    input  logic                             axi4_mm_clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  rwgen_pkg::axi_req_t              pop_data,
    input  logic                             empty,
    output logic                             pop,
    output logic                             arvalid,
    output logic [ADDR_W-1:0]                araddr,
    output logic [ID_W-1:0]                  arid,
    output rwgen_pkg::axi_user_t             aruser,
    input  logic                             arready,
    output logic                             awvalid,
    output logic [ADDR_W-1:0]                awaddr,
    output logic [ID_W-1:0]                  awid,
    output rwgen_pkg::axi_user_t             awuser,
    input  logic                             awready,
    output logic                             wvalid,
    output logic [rwgen_pkg::DATA_W-1:0]     wdata,
    output logic [rwgen_pkg::DATA_W/8-1:0]   wstrb,
    output logic                             wlast,
    input  logic                             wready,
    output logic                             done,
    output logic [rwgen_pkg::CNT_W-1:0]      issued_cnt,
    output logic [rwgen_pkg::CNT_W-1:0]      stall_cnt
);

    import rwgen_pkg::*;

    axi_req_t req_q;     // request currently on the bus
    logic     ar_pend;
    logic     aw_pend;
    logic     w_pend;
    logic     aw_ok;
    logic     w_ok;
    logic     rd_complete;
    logic     wr_complete;
    logic     complete;
    logic     idle;
    logic     stalled;

    // a channel counts as done if already accepted or accepted now
    assign aw_ok = ~aw_pend | awready;
    assign w_ok  = ~w_pend | wready;

    assign rd_complete = ar_pend & arready;
    assign wr_complete = (aw_pend | w_pend) & aw_ok & w_ok;
    assign complete    = rd_complete | wr_complete;
    assign idle        = ~(ar_pend | aw_pend | w_pend);

    // load next head as soon as the slot frees up
    assign pop = ~empty & (idle | complete);

    // one stall per cycle, even with both write channels held
    assign stalled = (ar_pend & ~arready) | (aw_pend & ~awready) | (w_pend & ~wready);

    assign arvalid = ar_pend;
    assign araddr  = ADDR_W'(req_q.addr);
    assign arid    = ID_W'(req_q.id);
    assign aruser  = req_q.user;

    assign awvalid = aw_pend;
    assign awaddr  = ADDR_W'(req_q.addr);
    assign awid    = ID_W'(req_q.id);
    assign awuser  = req_q.user;

    assign wvalid = w_pend;
    assign wdata  = '1;
    assign wstrb  = '1;
    assign wlast  = 1'b1;   // single-beat bursts

    always_ff @(posedge axi4_mm_clk) begin
        if (pop) begin
            req_q <= pop_data;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            ar_pend <= 1'b0;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else if (pop) begin
            ar_pend <= ~pop_data.is_write;
            aw_pend <= pop_data.is_write;
            w_pend  <= pop_data.is_write;
        end else begin
            if (arready) begin
                ar_pend <= 1'b0;
            end
            if (awready) begin
                aw_pend <= 1'b0;
            end
            if (wready) begin
                w_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            done       <= 1'b0;
            issued_cnt <= '0;
            stall_cnt  <= '0;
        end else begin
            done <= complete & req_q.last;
            if (start) begin
                issued_cnt <= '0;
                stall_cnt  <= '0;
            end else begin
                issued_cnt <= issued_cnt + CNT_W'(complete);
                stall_cnt  <= stall_cnt + CNT_W'(stalled);
            end
        end
    end

endmodule

//--- verilog/req_fifo.sv
// Request FIFO
// Small circular buffer with show-ahead head on pop_data; the payload
// type is set by the instantiating level.

`timescale 1ns/1ps

module req_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic [7:0]
) (
    input  logic     axi4_mm_clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];   // head shown ahead

    always_ff @(posedge axi4_mm_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;   // none or both
            endcase
        end
    end

endmodule

//--- verilog/req_producer.sv
// Request producer
// Latches the run configuration on start, steps the shift-xor seed and
// builds one addressed, tagged cache-line request per cycle into the FIFO.

`timescale 1ns/1ps

module req_producer #(
    parameter int ADDR_W = rwgen_pkg::ADDR_W,
    parameter int ID_W   = rwgen_pkg::ID_W
) (
    input  logic                axi4_mm_clk,
    input  logic                rst_n,
    input  rwgen_pkg::run_cfg_t cfg,
    input  logic                start,
    input  logic                full,
    output logic                push,
    output rwgen_pkg::axi_req_t push_data
);

    import rwgen_pkg::*;

    run_cfg_t          cfg_q;
    logic              active;
    logic [CNT_W-1:0]  cnt_q;      // index k of the next request
    logic [63:0]       seed_q;
    logic [63:0]       seed_next;
    logic [63:0]       seed_mask;
    logic [4:0]        keep_bits;
    logic [ADDR_W-1:0] offset;
    logic [ADDR_W-1:0] req_addr;
    logic [ID_W-1:0]   req_id;
    logic              is_last;

    assign seed_next = seed_q ^ (seed_q << 1) ^ (seed_q >> 1);

    // seed bits kept per range
    always_comb begin
        case (cfg_q.range_sel)
            RNG_32K:  keep_bits = 5'd9;
            RNG_128K: keep_bits = 5'd11;
            RNG_1M:   keep_bits = 5'd14;
            RNG_4M:   keep_bits = 5'd16;
            RNG_16M:  keep_bits = 5'd18;
            RNG_32M:  keep_bits = 5'd19;
            default:  keep_bits = 5'd0;
        endcase
    end

    assign seed_mask = (64'd1 << keep_bits) - 64'd1;

    always_comb begin
        if (cfg_q.range_sel == RNG_SEQ) begin
            offset = ADDR_W'(cnt_q) << LINE_SHIFT;         // k lines past base
        end else begin
            offset = ADDR_W'(seed_q & seed_mask) << LINE_SHIFT;
        end
    end

    assign req_addr = ADDR_W'(cfg_q.page_base) + offset;
    assign req_id   = ID_W'(cnt_q);                         // wraps at ID_W
    assign is_last  = (cnt_q == cfg_q.num_request - CNT_W'(1));

    always_comb begin
        push_data.is_write       = cfg_q.is_write;
        push_data.addr           = addr_t'(req_addr);
        push_data.id             = id_t'(req_id);
        push_data.user.region    = cfg_q.region;
        push_data.user.rsvd      = 2'b00;
        push_data.user.acc_class = cfg_q.acc_class;
        push_data.last           = is_last;
    end

    assign push = active & ~full;

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            active <= 1'b1;
            cnt_q  <= '0;
        end else if (push) begin
            cnt_q <= cnt_q + CNT_W'(1);
            if (is_last) begin
                active <= 1'b0;   // run fully generated
            end
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (start) begin
            cfg_q  <= cfg;
            seed_q <= cfg.seed;
        end else if (push) begin
            seed_q <= seed_next;
        end
    end

endmodule

//--- verilog/rwgen_pkg.sv
// Traffic generator shared definitions
// Widths, memory target and access class encodings, run configuration
// and the request record passed from producer to issuer.

package rwgen_pkg;

    parameter int ADDR_W     = 64;
    parameter int ID_W       = 12;
    parameter int DATA_W     = 512;
    parameter int CNT_W      = 16;
    parameter int LINE_SHIFT = 6;    // 64-byte cache line

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ID_W-1:0]   id_t;

    // memory target, top two user bits
    typedef enum logic [1:0] {
        RGN_HOST          = 2'b00,
        RGN_HDM_HOST_BIAS = 2'b10,
        RGN_HDM_DEV_BIAS  = 2'b11
    } region_e;

    // low two user bits, meaning depends on direction
    typedef enum logic [1:0] {
        ACC_NC         = 2'b00,  // non-cacheable
        ACC_SHARED_OWN = 2'b01,  // rd cacheable-shared, wr cacheable-owned
        ACC_OWN_PUSH   = 2'b10   // rd cacheable-owned, wr nc-push
    } access_class_e;

    typedef struct packed {
        region_e       region;
        logic [1:0]    rsvd;     // always zero
        access_class_e acc_class;
    } axi_user_t;

    typedef enum logic [2:0] {
        RNG_SEQ  = 3'd0,
        RNG_32K  = 3'd1,
        RNG_128K = 3'd2,
        RNG_1M   = 3'd3,
        RNG_4M   = 3'd4,
        RNG_16M  = 3'd5,
        RNG_32M  = 3'd6
    } range_sel_e;

    typedef struct packed {
        logic             is_write;
        region_e          region;
        access_class_e    acc_class;
        range_sel_e       range_sel;
        logic [CNT_W-1:0] num_request;
        addr_t            page_base;
        logic [63:0]      seed;
    } run_cfg_t;

    typedef struct packed {
        logic      is_write;
        addr_t     addr;
        id_t       id;
        axi_user_t user;
        logic      last;      // final request of the run
    } axi_req_t;

endpackage

//--- verilog/rwgen_top.sv
// CXL host-memory traffic generator top level
// Producer fills a small request FIFO, the issuer drives AXI4 AR or AW/W.
// busy spans a run from start until done.

`timescale 1ns/1ps

module rwgen_top #(
    parameter int ADDR_W     = rwgen_pkg::ADDR_W,
    parameter int ID_W       = rwgen_pkg::ID_W,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                           axi4_mm_clk,
    input  logic                           rst_n,
    input  rwgen_pkg::run_cfg_t            cfg,
    input  logic                           start,
    output logic                           arvalid,
    output logic [ADDR_W-1:0]              araddr,
    output logic [ID_W-1:0]                arid,
    output rwgen_pkg::axi_user_t           aruser,
    input  logic                           arready,
    output logic                           awvalid,
    output logic [ADDR_W-1:0]              awaddr,
    output logic [ID_W-1:0]                awid,
    output rwgen_pkg::axi_user_t           awuser,
    input  logic                           awready,
    output logic                           wvalid,
    output logic [rwgen_pkg::DATA_W-1:0]   wdata,
    output logic [rwgen_pkg::DATA_W/8-1:0] wstrb,
    output logic                           wlast,
    input  logic                           wready,
    output logic                           busy,
    output logic                           done,
    output logic [rwgen_pkg::CNT_W-1:0]    issued_cnt,
    output logic [rwgen_pkg::CNT_W-1:0]    stall_cnt
);

    import rwgen_pkg::*;

    logic     push;
    axi_req_t push_data;
    logic     full;
    logic     pop;
    axi_req_t pop_data;
    logic     empty;

    always_ff @(posedge axi4_mm_clk) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;   // drops as the done pulse ends
        end
    end

    req_producer #(.ADDR_W(ADDR_W), .ID_W(ID_W)) i_producer (
        .axi4_mm_clk, .rst_n, .cfg, .start, .full, .push, .push_data
    );

    req_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(axi_req_t)) i_fifo (
        .axi4_mm_clk, .rst_n, .push, .push_data, .pop, .pop_data, .full, .empty
    );

    axi_issue #(.ADDR_W(ADDR_W), .ID_W(ID_W)) i_issue (
        .axi4_mm_clk, .rst_n, .start, .pop_data, .empty, .pop,
        .arvalid, .araddr, .arid, .aruser, .arready,
        .awvalid, .awaddr, .awid, .awuser, .awready,
        .wvalid, .wdata, .wstrb, .wlast, .wready,
        .done, .issued_cnt, .stall_cnt
    );

endmodule
